// File: src/exec_pkg.sv
package exec_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int XLEN     = 64;  // Operand and result word
    localparam int UOP_W    = 64;  // Issued micro-op
    localparam int ROB_ID_W = 6;   // 64-entry ROB
    localparam int ALU_OP_W = 4;   // Opcode field
    localparam int SHAMT_W  = 6;   // Shift amount, low bits of B

    typedef logic [XLEN-1:0]     xdata_t;
    typedef logic [UOP_W-1:0]    uop_t;
    typedef logic [ROB_ID_W-1:0] rob_id_t;
    typedef logic [ALU_OP_W-1:0] alu_op_t;

    // ==============================
    // Uop layout
    // ==============================
    // [3:0] opcode, [31:16] A, [47:32] B, rest unused here
    localparam int UOP_OP_LSB  = 0;
    localparam int UOP_A_LSB   = 16;
    localparam int UOP_B_LSB   = 32;
    localparam int UOP_FIELD_W = 16;  // Both operands zero-extended to XLEN

    // ==============================
    // ALU opcodes
    // ==============================
    localparam alu_op_t OP_ADD = 4'd1;
    localparam alu_op_t OP_SUB = 4'd2;
    localparam alu_op_t OP_AND = 4'd3;
    localparam alu_op_t OP_OR  = 4'd4;
    localparam alu_op_t OP_XOR = 4'd5;
    localparam alu_op_t OP_SHL = 4'd6;  // A << B[5:0]
    localparam alu_op_t OP_SHR = 4'd7;  // A >> B[5:0], logical
    localparam alu_op_t OP_MOV = 4'd8;  // Result is B
    // Any other code gives zero

    // Completion slots toward the ROB
    // One per unit, so a full cycle of completions always fits
    localparam int NUM_SLOTS = 3;

endpackage

// File: src/int_alu.sv
`timescale 1ns/100ps

module int_alu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,   // No ready, one op per cycle
    input  exec_pkg::uop_t    issue_uop,
    input  exec_pkg::rob_id_t issue_rob_id,
    output logic              done,          // One cycle after issue
    output exec_pkg::rob_id_t rob_id,
    output exec_pkg::xdata_t  result
);
    import exec_pkg::*;

    // Decoded fields
    alu_op_t            alu_op;
    xdata_t             operand_a;
    xdata_t             operand_b;
    logic [SHAMT_W-1:0] shamt;
    xdata_t             alu_result;

    // ==============================
    // Operand extraction
    // ==============================
    assign alu_op    = issue_uop[UOP_OP_LSB +: ALU_OP_W];
    assign operand_a = XLEN'(issue_uop[UOP_A_LSB +: UOP_FIELD_W]);  // Zero-extended
    assign operand_b = XLEN'(issue_uop[UOP_B_LSB +: UOP_FIELD_W]);
    assign shamt     = operand_b[SHAMT_W-1:0];  // Only low bits of B

    // ==============================
    // Operation select
    // ==============================
    always_comb begin
        case (alu_op)
            OP_ADD:  alu_result = operand_a + operand_b;
            OP_SUB:  alu_result = operand_a - operand_b;  // Wraps in 64 bits
            OP_AND:  alu_result = operand_a & operand_b;
            OP_OR:   alu_result = operand_a | operand_b;
            OP_XOR:  alu_result = operand_a ^ operand_b;
            OP_SHL:  alu_result = operand_a << shamt;     // May grow past 16 bits
            OP_SHR:  alu_result = operand_a >> shamt;
            OP_MOV:  alu_result = operand_b;
            default: alu_result = '0;                     // Undefined codes
        endcase
    end

    // ==============================
    // Result register
    // ==============================
    // Done and result cleared, result computed every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done   <= issue_valid;
            result <= alu_result;
        end
    end

    // Tag follows the op, only looked at with done
    always_ff @(posedge clk) begin
        rob_id <= issue_rob_id;
    end

endmodule

// File: src/mul_pipe.sv
`timescale 1ns/100ps

module mul_pipe #(
    parameter int MUL_STAGES = 3  // Register stages, issue to done, at least 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              issue_valid,
    input  exec_pkg::uop_t    issue_uop,
    input  exec_pkg::rob_id_t issue_rob_id,
    output logic              done,
    output exec_pkg::rob_id_t rob_id,
    output exec_pkg::xdata_t  result
);
    import exec_pkg::*;

    localparam int PROD_W = 2 * UOP_FIELD_W;  // 16x16 fits in 32

    // Stage 0 holds operands, stages 1 and up hold the product
    logic [UOP_FIELD_W-1:0] a_q;
    logic [UOP_FIELD_W-1:0] b_q;
    logic [PROD_W-1:0]      product;
    logic                   vld_q  [MUL_STAGES];
    rob_id_t                rob_q  [MUL_STAGES];
    logic [PROD_W-1:0]      prod_q [1:MUL_STAGES-1];

    // ==============================
    // Operand stage and tag line
    // ==============================
    always_ff @(posedge clk) begin
        a_q      <= issue_uop[UOP_A_LSB +: UOP_FIELD_W];
        b_q      <= issue_uop[UOP_B_LSB +: UOP_FIELD_W];
        rob_q[0] <= issue_rob_id;
        for (int i = 1; i < MUL_STAGES; i++) begin
            rob_q[i] <= rob_q[i-1];  // ROB id rides with its valid
        end
    end

    // Multiply between stage 0 and stage 1
    assign product = a_q * b_q;

    // ==============================
    // Valid and product pipeline
    // ==============================
    // New multiply may enter every cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                vld_q[i] <= 1'b0;
            end
            for (int i = 1; i < MUL_STAGES; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            vld_q[0]  <= issue_valid;
            prod_q[1] <= product;
            for (int i = 1; i < MUL_STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
            for (int i = 2; i < MUL_STAGES; i++) begin
                prod_q[i] <= prod_q[i-1];  // Empty loop for two stages
            end
        end
    end

    // Last stage drives the packer
    assign done   = vld_q[MUL_STAGES-1];
    assign rob_id = rob_q[MUL_STAGES-1];
    assign result = XLEN'(prod_q[MUL_STAGES-1]);  // Zero-extended product

endmodule

// File: src/completion_packer.sv
`timescale 1ns/100ps

module completion_packer (
    input  logic                                              clk,
    input  logic                                              rst_n,
    input  logic                                              alu0_done,
    input  exec_pkg::rob_id_t                                 alu0_rob_id,
    input  exec_pkg::xdata_t                                  alu0_result,
    input  logic                                              alu1_done,
    input  exec_pkg::rob_id_t                                 alu1_rob_id,
    input  exec_pkg::xdata_t                                  alu1_result,
    input  logic                                              mul_done,
    input  exec_pkg::rob_id_t                                 mul_rob_id,
    input  exec_pkg::xdata_t                                  mul_result,
    output logic [exec_pkg::NUM_SLOTS-1:0]                    eu_complete,
    output logic [exec_pkg::NUM_SLOTS*exec_pkg::ROB_ID_W-1:0] eu_rob_id,
    output logic [exec_pkg::NUM_SLOTS*exec_pkg::XLEN-1:0]     eu_result
);
    import exec_pkg::*;

    localparam int NUM_SRCS = 3;  // alu0, alu1, mul

    // Sources in fixed priority order
    logic    src_done [NUM_SRCS];
    rob_id_t src_rob  [NUM_SRCS];
    xdata_t  src_res  [NUM_SRCS];

    // Packed slots before the register
    logic [NUM_SLOTS-1:0]          pack_vld;
    logic [NUM_SLOTS*ROB_ID_W-1:0] pack_rob;
    logic [NUM_SLOTS*XLEN-1:0]     pack_res;

    assign src_done[0] = alu0_done;
    assign src_rob[0]  = alu0_rob_id;
    assign src_res[0]  = alu0_result;
    assign src_done[1] = alu1_done;
    assign src_rob[1]  = alu1_rob_id;
    assign src_res[1]  = alu1_result;
    assign src_done[2] = mul_done;
    assign src_rob[2]  = mul_rob_id;
    assign src_res[2]  = mul_result;

    // ==============================
    // Compaction
    // ==============================
    // Each finished source takes the next free slot from 0 upward
    always_comb begin
        int unsigned slot;
        slot     = 0;
        pack_vld = '0;
        pack_rob = '0;  // Unused slots stay zero
        pack_res = '0;
        for (int i = 0; i < NUM_SRCS; i++) begin
            if (src_done[i] && slot < NUM_SLOTS) begin  // Never full, slots match units
                pack_vld[slot]                      = 1'b1;
                pack_rob[slot*ROB_ID_W +: ROB_ID_W] = src_rob[i];
                pack_res[slot*XLEN +: XLEN]         = src_res[i];
                slot++;
            end
        end
    end

    // ==============================
    // Output register toward ROB
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eu_complete <= '0;
            eu_rob_id   <= '0;
            eu_result   <= '0;
        end else begin
            eu_complete <= pack_vld;
            eu_rob_id   <= pack_rob;
            eu_result   <= pack_res;
        end
    end

endmodule

// File: src/op_counters.sv
`timescale 1ns/100ps

module op_counters #(
    parameter int CNT_W = 32  // Counter width, wraps when full
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             alu0_done,
    input  logic             alu1_done,
    input  logic             mul_done,
    output logic [CNT_W-1:0] perf_alu_ops,
    output logic [CNT_W-1:0] perf_mul_ops
);

    // Done pulses widened to counter width
    logic [CNT_W-1:0] alu_inc;
    logic [CNT_W-1:0] mul_inc;

    // 0, 1 or 2 ALU completions per cycle
    assign alu_inc = CNT_W'(alu0_done) + CNT_W'(alu1_done);
    assign mul_inc = CNT_W'(mul_done);

    // ==============================
    // Free-running counters
    // ==============================
    // Count lands on the edge after the done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            perf_alu_ops <= '0;
            perf_mul_ops <= '0;
        end else begin
            perf_alu_ops <= perf_alu_ops + alu_inc;
            perf_mul_ops <= perf_mul_ops + mul_inc;
        end
    end

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/100ps

module exec_cluster #(
    parameter int MUL_STAGES = 3,   // Multiplier latency in cycles
    parameter int CNT_W      = 32   // Perf counter width
) (
    input  logic                                              clk,
    input  logic                                              rst_n,

    // Issue ports from the IQ, valid only, never stalled
    input  logic                                              alu0_issue_valid,
    input  exec_pkg::uop_t                                    alu0_issue_uop,
    input  exec_pkg::rob_id_t                                 alu0_issue_rob_id,
    input  logic                                              alu1_issue_valid,
    input  exec_pkg::uop_t                                    alu1_issue_uop,
    input  exec_pkg::rob_id_t                                 alu1_issue_rob_id,
    input  logic                                              mul_issue_valid,
    input  exec_pkg::uop_t                                    mul_issue_uop,
    input  exec_pkg::rob_id_t                                 mul_issue_rob_id,

    // Completion toward the ROB, flat slots
    output logic [exec_pkg::NUM_SLOTS-1:0]                    eu_complete,
    output logic [exec_pkg::NUM_SLOTS*exec_pkg::ROB_ID_W-1:0] eu_rob_id,
    output logic [exec_pkg::NUM_SLOTS*exec_pkg::XLEN-1:0]     eu_result,

    // Perf counters
    output logic [CNT_W-1:0]                                  perf_alu_ops,
    output logic [CNT_W-1:0]                                  perf_mul_ops
);
    import exec_pkg::*;

    // Unit outputs into the packer
    logic    alu0_done;
    rob_id_t alu0_rob_id;
    xdata_t  alu0_result;
    logic    alu1_done;
    rob_id_t alu1_rob_id;
    xdata_t  alu1_result;
    logic    mul_done;
    rob_id_t mul_rob_id;
    xdata_t  mul_result;

    // ==============================
    // Execute stage
    // ==============================
    int_alu u_alu0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (alu0_issue_valid),
        .issue_uop    (alu0_issue_uop),
        .issue_rob_id (alu0_issue_rob_id),
        .done         (alu0_done),
        .rob_id       (alu0_rob_id),
        .result       (alu0_result)
    );

    int_alu u_alu1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (alu1_issue_valid),
        .issue_uop    (alu1_issue_uop),
        .issue_rob_id (alu1_issue_rob_id),
        .done         (alu1_done),
        .rob_id       (alu1_rob_id),
        .result       (alu1_result)
    );

    mul_pipe #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (mul_issue_valid),
        .issue_uop    (mul_issue_uop),
        .issue_rob_id (mul_issue_rob_id),
        .done         (mul_done),
        .rob_id       (mul_rob_id),
        .result       (mul_result)
    );

    // ==============================
    // Completion and counters
    // ==============================
    // One more register, ALU total 2 cycles, MUL total MUL_STAGES+1
    completion_packer u_packer (
        .clk         (clk),
        .rst_n       (rst_n),
        .alu0_done   (alu0_done),
        .alu0_rob_id (alu0_rob_id),
        .alu0_result (alu0_result),
        .alu1_done   (alu1_done),
        .alu1_rob_id (alu1_rob_id),
        .alu1_result (alu1_result),
        .mul_done    (mul_done),
        .mul_rob_id  (mul_rob_id),
        .mul_result  (mul_result),
        .eu_complete (eu_complete),
        .eu_rob_id   (eu_rob_id),
        .eu_result   (eu_result)
    );

    op_counters #(
        .CNT_W (CNT_W)
    ) u_counters (
        .clk          (clk),
        .rst_n        (rst_n),
        .alu0_done    (alu0_done),
        .alu1_done    (alu1_done),
        .mul_done     (mul_done),
        .perf_alu_ops (perf_alu_ops),
        .perf_mul_ops (perf_mul_ops)
    );

endmodule

// File: sim/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ==============================
// Stimulus helpers
// ==============================
// Fibonacci LFSR, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
endfunction

// Opcode [3:0], A [31:16], B [47:32], junk in the unused bits
function automatic uop_t make_uop(input alu_op_t op, input logic [15:0] a,
                                  input logic [15:0] b, input logic [27:0] junk);
    return {junk[27:12], b, a, junk[11:0], op};
endfunction

// ==============================
// Reference results
// ==============================
// ALU, both operands zero-extended to 64 bits
function automatic xdata_t ref_alu(input alu_op_t op, input logic [15:0] a,
                                   input logic [15:0] b);
    xdata_t wide_a;
    xdata_t wide_b;
    xdata_t res;
    wide_a = {48'h0, a};
    wide_b = {48'h0, b};
    case (op)
        OP_ADD:  res = wide_a + wide_b;
        OP_SUB:  res = wide_a - wide_b;   // Borrow runs up to bit 63
        OP_AND:  res = wide_a & wide_b;
        OP_OR:   res = wide_a | wide_b;
        OP_XOR:  res = wide_a ^ wide_b;
        OP_SHL:  res = wide_a << b[5:0];  // Shift amount is B[5:0]
        OP_SHR:  res = wide_a >> b[5:0];
        OP_MOV:  res = wide_b;
        default: res = 64'h0;
    endcase
    return res;
endfunction

// 16x16 product always fits in the low 32 bits
function automatic xdata_t ref_mul(input logic [15:0] a, input logic [15:0] b);
    logic [31:0] prod;
    prod = {16'h0, a} * {16'h0, b};
    return {32'h0, prod};
endfunction

`endif

// File: sim/exec_cluster_tb.sv
`timescale 1ns/100ps

module exec_cluster_tb;
    import exec_pkg::*;

    `include "tb_model.svh"

    localparam int          RESET_CYCLES = 16;
    localparam int          DRIVE_DELAY  = 2;     // ns after the rising edge
    localparam int          ALU_LAT      = 2;     // Issue to eu_complete, in cycles
    localparam int          MUL_LAT      = 4;
    localparam int          RAND_CYCLES  = 2000;
    localparam int          WAIT_LIMIT   = 64;    // Cycles allowed for any single wait
    localparam logic [31:0] LFSR_SEED    = 32'd92356;

    // One expected completion from one source
    typedef struct packed {
        logic    vld;
        rob_id_t rob;
        xdata_t  res;
    } cpl_t;

    logic                          clk;
    logic                          rst_n;
    logic                          compare_on;  // Outputs are known from here on
    logic                          alu0_issue_valid;
    uop_t                          alu0_issue_uop;
    rob_id_t                       alu0_issue_rob_id;
    logic                          alu1_issue_valid;
    uop_t                          alu1_issue_uop;
    rob_id_t                       alu1_issue_rob_id;
    logic                          mul_issue_valid;
    uop_t                          mul_issue_uop;
    rob_id_t                       mul_issue_rob_id;
    logic [NUM_SLOTS-1:0]          eu_complete;
    logic [NUM_SLOTS*ROB_ID_W-1:0] eu_rob_id;
    logic [NUM_SLOTS*XLEN-1:0]     eu_result;
    logic [31:0]                   perf_alu_ops;
    logic [31:0]                   perf_mul_ops;

    cpl_t        alu0_line [ALU_LAT];  // Delay lines, index 0 newest
    cpl_t        alu1_line [ALU_LAT];
    cpl_t        mul_line  [MUL_LAT];
    logic [31:0] lfsr_state;
    int unsigned alu_issued;
    int unsigned mul_issued;

    exec_cluster dut0 (.*);

    // ==============================
    // Clock and reset
    // ==============================
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        compare_on = 1'b0;
        rst_n      = 1'b0;
        @(posedge clk);
        compare_on = 1'b1;  // First edge under reset clears every flop
        repeat (RESET_CYCLES - 1) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
    end

    // ==============================
    // Checks and failures
    // ==============================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // ==============================
    // Reference model
    // ==============================
    function automatic cpl_t make_entry(input logic vld, input logic is_mul, input uop_t uop,
                                        input rob_id_t rob);
        cpl_t e;
        e.vld = vld;
        e.rob = rob;
        e.res = is_mul ? ref_mul(uop[31:16], uop[47:32])
                       : ref_alu(uop[3:0], uop[31:16], uop[47:32]);
        return e;
    endfunction

    // Finished sources fill slots from 0 in order alu0, alu1, mul
    function automatic void pack_reference(input cpl_t src0, input cpl_t src1, input cpl_t src2,
                                           output logic [NUM_SLOTS-1:0] cpl,
                                           output logic [NUM_SLOTS*ROB_ID_W-1:0] rob,
                                           output logic [NUM_SLOTS*XLEN-1:0] res);
        cpl_t srcs [3];
        int   slot;
        srcs[0] = src0;
        srcs[1] = src1;
        srcs[2] = src2;
        cpl     = '0;
        rob     = '0;  // Unused slots read as zero
        res     = '0;
        slot    = 0;
        for (int i = 0; i < 3; i++) begin
            if (srcs[i].vld) begin
                cpl[slot]                      = 1'b1;
                rob[slot*ROB_ID_W +: ROB_ID_W] = srcs[i].rob;
                res[slot*XLEN +: XLEN]         = srcs[i].res;
                slot++;
            end
        end
    endfunction

    // Inputs are stable here, driven a few ns after the previous edge
    always @(posedge clk) begin
        for (int i = ALU_LAT - 1; i > 0; i--) begin
            alu0_line[i] = alu0_line[i-1];
            alu1_line[i] = alu1_line[i-1];
        end
        for (int i = MUL_LAT - 1; i > 0; i--) begin
            mul_line[i] = mul_line[i-1];
        end
        alu0_line[0] = make_entry(rst_n && alu0_issue_valid, 1'b0, alu0_issue_uop,
                                  alu0_issue_rob_id);
        alu1_line[0] = make_entry(rst_n && alu1_issue_valid, 1'b0, alu1_issue_uop,
                                  alu1_issue_rob_id);
        mul_line[0]  = make_entry(rst_n && mul_issue_valid, 1'b1, mul_issue_uop,
                                  mul_issue_rob_id);
    end

    // Compare every slot mid-cycle, away from both edges
    always @(negedge clk) begin
        logic [NUM_SLOTS-1:0]          exp_cpl;
        logic [NUM_SLOTS*ROB_ID_W-1:0] exp_rob;
        logic [NUM_SLOTS*XLEN-1:0]     exp_res;
        if (compare_on) begin
            pack_reference(alu0_line[ALU_LAT-1], alu1_line[ALU_LAT-1], mul_line[MUL_LAT-1],
                           exp_cpl, exp_rob, exp_res);
            check_value("eu_complete", 64'(eu_complete), 64'(exp_cpl));
            for (int s = 0; s < NUM_SLOTS; s++) begin
                check_value($sformatf("eu_rob_id[%0d]", s),
                            64'(eu_rob_id[s*ROB_ID_W +: ROB_ID_W]),
                            64'(exp_rob[s*ROB_ID_W +: ROB_ID_W]));
                check_value($sformatf("eu_result[%0d]", s), eu_result[s*XLEN +: XLEN],
                            exp_res[s*XLEN +: XLEN]);
            end
            if (!rst_n) begin
                check_value("perf_alu_ops", 64'(perf_alu_ops), 64'h0);  // Held in reset
                check_value("perf_mul_ops", 64'(perf_mul_ops), 64'h0);
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic clear_ports();
        alu0_issue_valid  = 1'b0;
        alu0_issue_uop    = '0;
        alu0_issue_rob_id = '0;
        alu1_issue_valid  = 1'b0;
        alu1_issue_uop    = '0;
        alu1_issue_rob_id = '0;
        mul_issue_valid   = 1'b0;
        mul_issue_uop     = '0;
        mul_issue_rob_id  = '0;
    endtask

    task automatic step_cycle();  // To the next drive point, all ports idle
        @(posedge clk);
        #DRIVE_DELAY;
        clear_ports();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step_cycle();
    endtask

    // Unit 0 and 1 are the ALUs, 2 is the multiplier
    task automatic issue(input int unit, input alu_op_t op, input logic [15:0] a,
                         input logic [15:0] b, input rob_id_t rob, input logic [27:0] junk);
        case (unit)
            0: begin
                alu0_issue_valid  = 1'b1;
                alu0_issue_uop    = make_uop(op, a, b, junk);
                alu0_issue_rob_id = rob;
            end
            1: begin
                alu1_issue_valid  = 1'b1;
                alu1_issue_uop    = make_uop(op, a, b, junk);
                alu1_issue_rob_id = rob;
            end
            default: begin
                mul_issue_valid  = 1'b1;
                mul_issue_uop    = make_uop(op, a, b, junk);  // Opcode ignored by the MUL
                mul_issue_rob_id = rob;
            end
        endcase
        if (unit == 2) mul_issued++;
        else alu_issued++;
    endtask

    function automatic rob_id_t fresh_tag();
        return rob_id_t'(alu_issued + mul_issued);  // Wraps every 64 ops
    endfunction

    // One LFSR step per bit, newest bit at the bottom
    task automatic draw_bits(input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[62:0], lfsr_state[0]};
        end
    endtask

    task automatic random_issue(input int unit);
        logic [63:0] vld;
        logic [63:0] op;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] rob;
        logic [63:0] junk;
        draw_bits(1, vld);
        if (vld[0]) begin
            draw_bits(4, op);
            draw_bits(16, a);
            draw_bits(16, b);
            draw_bits(6, rob);
            draw_bits(28, junk);
            issue(unit, op[3:0], a[15:0], b[15:0], rob[5:0], junk[27:0]);
        end
    endtask

    // ==============================
    // Directed tests
    // ==============================
    // Every opcode alone on one ALU, 9 is undefined
    task automatic run_opcodes();
        logic [15:0] a_vals [2];
        logic [15:0] b_vals [2];
        a_vals[0] = 16'h7F5A;  // SUB wraps, SHL by 20 grows past 16 bits
        b_vals[0] = 16'h8014;
        a_vals[1] = 16'hC3A5;  // Small shift amount
        b_vals[1] = 16'h0003;
        for (int unit = 0; unit < 2; unit++) begin
            for (int p = 0; p < 2; p++) begin
                for (int op = 1; op <= 9; op++) begin
                    step_cycle();
                    issue(unit, alu_op_t'(op), a_vals[p], b_vals[p], fresh_tag(), 28'hA5C3E1F);
                    idle_cycles(2);
                end
            end
        end
    endtask

    task automatic run_multiplies();
        step_cycle();
        issue(2, OP_ADD, 16'hFFFF, 16'hFFFF, fresh_tag(), 28'h0);  // Largest product
        idle_cycles(5);
        for (int i = 0; i < 6; i++) begin  // Back to back, several in flight
            step_cycle();
            issue(2, OP_ADD, 16'(32'h1357 + i * 32'h2211), 16'(32'hFEDC - i * 32'h0F0F),
                  fresh_tag(), 28'hFFFFFFF);
        end
        idle_cycles(5);
    endtask

    // MUL issued two cycles ahead lands with the ALUs
    task automatic run_packing();
        for (int mask = 1; mask < 8; mask++) begin
            step_cycle();
            if (mask[2]) issue(2, OP_ADD, 16'h0321, 16'h00F0, fresh_tag(), 28'h0);
            idle_cycles(2);
            if (mask[0]) issue(0, OP_ADD, 16'h1111, 16'h2222, fresh_tag(), 28'h0);
            if (mask[1]) issue(1, OP_XOR, 16'hF0F0, 16'h0FF0, fresh_tag(), 28'h0);
            idle_cycles(5);
        end
    endtask

    // ==============================
    // Waits
    // ==============================
    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < RESET_CYCLES + WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) fail_run("Timeout: reset was never released");
    endtask

    function automatic logic lines_busy();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < ALU_LAT; i++) busy = busy | alu0_line[i].vld | alu1_line[i].vld;
        for (int i = 0; i < MUL_LAT; i++) busy = busy | mul_line[i].vld;
        return busy;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        step_cycle();  // Last random ops are sampled here
        while (lines_busy() && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (lines_busy()) fail_run("Timeout: completions did not drain");
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clear_ports();
        lfsr_state = LFSR_SEED;
        alu_issued = 0;
        mul_issued = 0;
        for (int i = 0; i < MUL_LAT; i++) begin
            mul_line[i] = '0;
            if (i < ALU_LAT) begin
                alu0_line[i] = '0;
                alu1_line[i] = '0;
            end
        end
        wait_reset_release();
        @(negedge clk);
        check_value("perf_alu_ops", 64'(perf_alu_ops), 64'h0);  // Right after release
        check_value("perf_mul_ops", 64'(perf_mul_ops), 64'h0);
        run_opcodes();
        run_multiplies();
        run_packing();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            step_cycle();
            for (int unit = 0; unit < 3; unit++) random_issue(unit);
        end
        wait_drain();
        check_value("perf_alu_ops", 64'(perf_alu_ops), 64'(alu_issued));
        check_value("perf_mul_ops", 64'(perf_mul_ops), 64'(mul_issued));
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: exec_cluster.f
+incdir+sim
src/exec_pkg.sv
src/int_alu.sv
src/mul_pipe.sv
src/completion_packer.sv
src/op_counters.sv
src/exec_cluster.sv
sim/exec_cluster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the exec_cluster testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module exec_cluster_tb \
    -Mdir obj_dir -f exec_cluster.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vexec_cluster_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit 1
fi

echo "Simulation finished cleanly"
exit 0
